//--- include/ahb_slave_cfg.svh
// Bus widths, window count and reset window map for the AHB slave.
// Included by the package, the interface and every RTL module that
// sizes a port from these values.

`ifndef AHB_SLAVE_CFG_SVH
`define AHB_SLAVE_CFG_SVH

`define AHB_DATA_WIDTH 32
`define AHB_ADDR_WIDTH 32

// one select line per APB window
`define APB_SLAVES 4

// config registers live at 0 .. CFG_LAST_ADDR
`define CFG_LAST_ADDR 8

// window bases after reset
`define SLAVE_BASE_0 'h8000_0000
`define SLAVE_BASE_1 'h8400_0000
`define SLAVE_BASE_2 'h8800_0000
`define SLAVE_BASE_3 'h8C00_0000

`define SLAVE_SIZE_DEFAULT 'h0000_03FF

`endif

//--- hdl/ahb_slave_pkg.sv
// Types shared by the AHB slave modules and its testbench.
// Referenced with scoped names, never imported.
`default_nettype none

`include "ahb_slave_cfg.svh"

package ahb_slave_pkg;

	typedef enum logic [1:0] {IDLE = 2'b00, BUSY = 2'b01, NONSEQ = 2'b10, SEQ = 2'b11} htrans_e;

	typedef enum logic [2:0] {
		BYTE     = 3'b000,
		HALFWORD = 3'b001,
		WORD     = 3'b010,
		DWORD    = 3'b011,
		LINE4    = 3'b100,
		LINE8    = 3'b101,
		LINE16   = 3'b110,
		LINE32   = 3'b111  // 1024 bit
	} hsize_e;

	// odd index holds a window base, even index its size
	typedef enum logic [3:0] {
		REG_RESERVED = 4'd0,
		REG_BASE0 = 4'd1,
		REG_SIZE0 = 4'd2,
		REG_BASE1 = 4'd3,
		REG_SIZE1 = 4'd4,
		REG_BASE2 = 4'd5,
		REG_SIZE2 = 4'd6,
		REG_BASE3 = 4'd7,
		REG_SIZE3 = 4'd8
	} cfg_reg_e;

	typedef enum logic [1:0] {RESP_OKAY, RESP_ERR_FIRST, RESP_ERR_SECOND} resp_state_e;

	typedef enum logic [1:0] {OKAY = 2'b00, ERROR = 2'b10} hresp_e;

	typedef struct packed {
		logic [`AHB_DATA_WIDTH-1:0] base;
		logic [`AHB_DATA_WIDTH-1:0] size;
	} slave_window_t;

endpackage

`default_nettype wire

//--- hdl/ahb_xfer_if.sv
// Registered AHB address phase, shared between the capture stage,
// the config register file and the protocol checker.
`timescale 1ns/1ps
`default_nettype none

`include "ahb_slave_cfg.svh"

interface ahb_xfer_if;

	logic [`AHB_ADDR_WIDTH-1:0] addr;
	logic write;
	ahb_slave_pkg::hsize_e size;
	ahb_slave_pkg::htrans_e trans;
	logic cfg_hit;
	logic accepted;  // one cycle per NONSEQ/SEQ taken

	// transfer before the current one
	ahb_slave_pkg::htrans_e prev_trans;
	ahb_slave_pkg::hsize_e prev_size;
	logic prev_write;

	modport capture (output addr, write, size, trans, cfg_hit, accepted,
		prev_trans, prev_size, prev_write);

	modport regs (input addr, write, trans, cfg_hit, accepted);

	modport check (input addr, write, size, trans, cfg_hit, accepted,
		prev_trans, prev_size, prev_write);

endinterface

`default_nettype wire

//--- hdl/ahb_addr_phase.sv
// Address phase register. Samples the bus whenever Hreadyin is high and
// flags NONSEQ/SEQ phases as accepted for the following data phase.
// Also keeps the transfer before it for the burst checks.
`timescale 1ns/1ps
`default_nettype none

`include "ahb_slave_cfg.svh"

module ahb_addr_phase (
	input wire Hclk,
	input wire Hresetn,
	input wire [`AHB_ADDR_WIDTH-1:0] Haddr,
	input wire ahb_slave_pkg::htrans_e Htrans,
	input wire ahb_slave_pkg::hsize_e Hsize,
	input wire Hwrite,
	input wire Hreadyin,
	input wire cfg_hit,
	ahb_xfer_if.capture xfer
);

	logic accept;

	assign accept = Hreadyin && (Htrans == ahb_slave_pkg::NONSEQ || Htrans == ahb_slave_pkg::SEQ);

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			xfer.accepted <= 1'b0;
			xfer.trans <= ahb_slave_pkg::IDLE;
			xfer.prev_trans <= ahb_slave_pkg::IDLE;
		end
		else
		begin
			xfer.accepted <= accept;
			if (Hreadyin)  // held while the bus is stalled
			begin
				xfer.prev_trans <= xfer.trans;
				xfer.trans <= Htrans;
			end
		end
	end

	// payload of the phase, no reset
	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
		begin
			xfer.prev_size <= xfer.size;
			xfer.prev_write <= xfer.write;
			xfer.addr <= Haddr;
			xfer.size <= Hsize;
			xfer.write <= Hwrite;
			xfer.cfg_hit <= cfg_hit;
		end
	end

endmodule

`default_nettype wire

//--- hdl/ahb_cfg_regs.sv
// Window base and size registers at config addresses 1 to 8.
// Written with Hwdata in the data phase of a config write, read back
// on config_reg_data during the data phase of a config read.
// Index 0 is reserved and reads as zero.
`timescale 1ns/1ps
`default_nettype none

`include "ahb_slave_cfg.svh"

module ahb_cfg_regs (
	input wire Hclk,
	input wire Hresetn,
	input wire [`AHB_DATA_WIDTH-1:0] Hwdata,
	ahb_xfer_if.regs xfer,
	output ahb_slave_pkg::slave_window_t windows [`APB_SLAVES],
	output logic [`AHB_DATA_WIDTH-1:0] config_reg_data
);

	ahb_slave_pkg::cfg_reg_e idx;
	logic cfg_wr;
	logic cfg_rd;
	logic [`AHB_DATA_WIDTH-1:0] rd_mux;

	assign idx = ahb_slave_pkg::cfg_reg_e'(xfer.addr[3:0]);
	assign cfg_wr = xfer.accepted && xfer.write && xfer.cfg_hit;
	// trans holds NONSEQ/SEQ for the whole data phase
	assign cfg_rd = xfer.cfg_hit && !xfer.write &&
		(xfer.trans == ahb_slave_pkg::NONSEQ || xfer.trans == ahb_slave_pkg::SEQ);

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			windows[0] <= '{base: `SLAVE_BASE_0, size: `SLAVE_SIZE_DEFAULT};
			windows[1] <= '{base: `SLAVE_BASE_1, size: `SLAVE_SIZE_DEFAULT};
			windows[2] <= '{base: `SLAVE_BASE_2, size: `SLAVE_SIZE_DEFAULT};
			windows[3] <= '{base: `SLAVE_BASE_3, size: `SLAVE_SIZE_DEFAULT};
		end
		else if (cfg_wr)
		begin
			case (idx)
				ahb_slave_pkg::REG_BASE0: windows[0].base <= Hwdata;
				ahb_slave_pkg::REG_SIZE0: windows[0].size <= Hwdata;
				ahb_slave_pkg::REG_BASE1: windows[1].base <= Hwdata;
				ahb_slave_pkg::REG_SIZE1: windows[1].size <= Hwdata;
				ahb_slave_pkg::REG_BASE2: windows[2].base <= Hwdata;
				ahb_slave_pkg::REG_SIZE2: windows[2].size <= Hwdata;
				ahb_slave_pkg::REG_BASE3: windows[3].base <= Hwdata;
				ahb_slave_pkg::REG_SIZE3: windows[3].size <= Hwdata;
				default: ;  // reserved, write dropped
			endcase
		end
	end

	always_comb
	begin
		case (idx)
			ahb_slave_pkg::REG_BASE0: rd_mux = windows[0].base;
			ahb_slave_pkg::REG_SIZE0: rd_mux = windows[0].size;
			ahb_slave_pkg::REG_BASE1: rd_mux = windows[1].base;
			ahb_slave_pkg::REG_SIZE1: rd_mux = windows[1].size;
			ahb_slave_pkg::REG_BASE2: rd_mux = windows[2].base;
			ahb_slave_pkg::REG_SIZE2: rd_mux = windows[2].size;
			ahb_slave_pkg::REG_BASE3: rd_mux = windows[3].base;
			ahb_slave_pkg::REG_SIZE3: rd_mux = windows[3].size;
			default: rd_mux = '0;
		endcase
	end

	assign config_reg_data = cfg_rd ? rd_mux : '0;

endmodule

`default_nettype wire

//--- hdl/ahb_slave_decode.sv
// Address decode for the current address phase.
// Drives one APB select per programmed window, flags the config region
// and raises valid for transfers to be forwarded to the APB side.
`timescale 1ns/1ps
`default_nettype none

`include "ahb_slave_cfg.svh"

module ahb_slave_decode (
	input wire [`AHB_ADDR_WIDTH-1:0] Haddr,
	input wire ahb_slave_pkg::htrans_e Htrans,
	input wire Hwrite,
	input wire Hreadyin,
	input wire ahb_slave_pkg::slave_window_t windows [`APB_SLAVES],
	input wire resp_active,
	output logic [`APB_SLAVES-1:0] Pselx_out,
	output logic valid,
	output logic cfg_hit
);

	logic [`AHB_DATA_WIDTH:0] win_end [`APB_SLAVES];  // extra bit so base+size cannot wrap
	logic active_trans;

	always_comb
	begin
		for (int i = 0; i < `APB_SLAVES; i++)
		begin
			win_end[i] = {1'b0, windows[i].base} + {1'b0, windows[i].size};
			Pselx_out[i] = (Haddr >= windows[i].base) && ({1'b0, Haddr} < win_end[i]);
		end
	end

	assign cfg_hit = (Haddr <= `CFG_LAST_ADDR);
	assign active_trans = (Htrans == ahb_slave_pkg::NONSEQ) || (Htrans == ahb_slave_pkg::SEQ);

	// config writes stay local
	assign valid = Hreadyin && active_trans && !resp_active && !(cfg_hit && Hwrite);

endmodule

`default_nettype wire

//--- hdl/ahb_err_resp.sv
// Protocol checker and two-cycle ERROR response.
// The checks run in the data phase of each accepted transfer. A failing
// transfer gets ERROR with Hreadyout low, then ERROR with Hreadyout high.
// Outside errors Hreadyout follows Hreadyout_in, except for config writes.
`timescale 1ns/1ps
`default_nettype none

`include "ahb_slave_cfg.svh"

module ahb_err_resp (
	input wire Hclk,
	input wire Hresetn,
	input wire Hreadyout_in,
	ahb_xfer_if.check xfer,
	output ahb_slave_pkg::hresp_e Hresp,
	output logic Hreadyout,
	output logic resp_active
);

	ahb_slave_pkg::resp_state_e state_q;
	ahb_slave_pkg::resp_state_e state;
	logic active_d;  // phase was accepted during an error response
	logic [6:0] align_mask;
	logic misaligned;
	logic seq_after_idle;
	logic seq_mismatch;
	logic too_wide;
	logic err_found;
	logic cfg_wr;

	assign align_mask = 7'((8'd1 << xfer.size) - 8'd1);
	assign misaligned = !xfer.cfg_hit && (|(xfer.addr[6:0] & align_mask));
	assign seq_after_idle = (xfer.trans == ahb_slave_pkg::SEQ) &&
		(xfer.prev_trans == ahb_slave_pkg::IDLE);
	assign seq_mismatch = (xfer.trans == ahb_slave_pkg::SEQ) &&
		(xfer.prev_trans != ahb_slave_pkg::IDLE) &&
		((xfer.size != xfer.prev_size) || (xfer.write != xfer.prev_write));
	assign too_wide = ((11'd8 << xfer.size) > `AHB_DATA_WIDTH);
	assign err_found = misaligned || seq_after_idle || seq_mismatch || too_wide;

	// first error cycle is the data phase itself
	always_comb
	begin
		state = state_q;
		if (state_q == ahb_slave_pkg::RESP_OKAY && xfer.accepted && !active_d && err_found)
			state = ahb_slave_pkg::RESP_ERR_FIRST;
	end

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			state_q <= ahb_slave_pkg::RESP_OKAY;
			active_d <= 1'b0;
		end
		else
		begin
			active_d <= resp_active;
			case (state)
				ahb_slave_pkg::RESP_ERR_FIRST: state_q <= ahb_slave_pkg::RESP_ERR_SECOND;
				default: state_q <= ahb_slave_pkg::RESP_OKAY;
			endcase
		end
	end

	assign resp_active = (state != ahb_slave_pkg::RESP_OKAY);
	assign cfg_wr = xfer.accepted && xfer.write && xfer.cfg_hit;
	assign Hresp = resp_active ? ahb_slave_pkg::ERROR : ahb_slave_pkg::OKAY;

	always_comb
	begin
		case (state)
			ahb_slave_pkg::RESP_ERR_FIRST: Hreadyout = 1'b0;
			ahb_slave_pkg::RESP_ERR_SECOND: Hreadyout = 1'b1;
			default: Hreadyout = cfg_wr ? 1'b1 : Hreadyout_in;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/ahb_slave_top.sv
// AHB slave side of the AHB-to-APB bridge.
// Decodes the APB selects, holds the window config registers and
// answers protocol errors with the two-cycle ERROR response.
`timescale 1ns/1ps
`default_nettype none

`include "ahb_slave_cfg.svh"

module ahb_slave_top (
	input wire Hclk,
	input wire Hresetn,
	input wire [1:0] Htrans,
	input wire [2:0] Hsize,
	input wire Hreadyin,
	input wire [`AHB_DATA_WIDTH-1:0] Hwdata,
	input wire [`AHB_ADDR_WIDTH-1:0] Haddr,
	input wire Hwrite,
	input wire Hreadyout_in,
	output logic [1:0] Hresp,
	output logic Hreadyout,
	output logic [`APB_SLAVES-1:0] Pselx_out,
	output logic valid,
	output logic [`AHB_DATA_WIDTH-1:0] config_reg_data
);

	ahb_slave_pkg::htrans_e htrans;
	ahb_slave_pkg::hsize_e hsize;
	ahb_slave_pkg::hresp_e hresp;
	ahb_slave_pkg::slave_window_t windows [`APB_SLAVES];
	logic cfg_hit;
	logic resp_active;

	assign htrans = ahb_slave_pkg::htrans_e'(Htrans);
	assign hsize = ahb_slave_pkg::hsize_e'(Hsize);
	assign Hresp = hresp;

	ahb_xfer_if xfer ();

	ahb_addr_phase u_addr_phase (.Hclk(Hclk), .Hresetn(Hresetn), .Haddr(Haddr),
		.Htrans(htrans), .Hsize(hsize), .Hwrite(Hwrite), .Hreadyin(Hreadyin),
		.cfg_hit(cfg_hit), .xfer(xfer));

	ahb_cfg_regs u_cfg_regs (.Hclk(Hclk), .Hresetn(Hresetn), .Hwdata(Hwdata),
		.xfer(xfer), .windows(windows), .config_reg_data(config_reg_data));

	ahb_slave_decode u_decode (.Haddr(Haddr), .Htrans(htrans), .Hwrite(Hwrite),
		.Hreadyin(Hreadyin), .windows(windows), .resp_active(resp_active),
		.Pselx_out(Pselx_out), .valid(valid), .cfg_hit(cfg_hit));

	ahb_err_resp u_err_resp (.Hclk(Hclk), .Hresetn(Hresetn), .Hreadyout_in(Hreadyout_in),
		.xfer(xfer), .Hresp(hresp), .Hreadyout(Hreadyout), .resp_active(resp_active));

endmodule

`default_nettype wire

//--- sim/ahb_slave_chk.sv
// Concurrent checks on the ERROR response handshake of ahb_err_resp.
// Bound into every ahb_err_resp instance by the bind at the bottom.
`timescale 1ns/1ps
`default_nettype none

module ahb_slave_chk (
	input wire Hclk,
	input wire Hresetn,
	input wire ahb_slave_pkg::hresp_e Hresp,
	input wire Hreadyout
);

	int failures = 0;

	// first cycle of an ERROR response
	sequence err_start;
		(Hresp == ahb_slave_pkg::ERROR) && ($past(Hresp) != ahb_slave_pkg::ERROR);
	endsequence

	a_err_two_cycles: assert property (@(posedge Hclk) disable iff (!Hresetn)
		err_start |=> (Hresp == ahb_slave_pkg::ERROR) ##1 (Hresp == ahb_slave_pkg::OKAY))
	else
	begin
		$error("ERROR response not exactly two cycles long");
		failures++;
	end

	a_err_ready: assert property (@(posedge Hclk) disable iff (!Hresetn)
		err_start |-> !Hreadyout ##1 Hreadyout)
	else
	begin
		$error("Hreadyout not low then high during ERROR response");
		failures++;
	end

	a_reset_okay: assert property (@(posedge Hclk) $rose(Hresetn) |-> Hresp == ahb_slave_pkg::OKAY)
	else
	begin
		$error("Hresp not OKAY after reset");
		failures++;
	end

endmodule

bind ahb_err_resp ahb_slave_chk u_chk (.Hclk(Hclk), .Hresetn(Hresetn), .Hresp(Hresp),
	.Hreadyout(Hreadyout));

`default_nettype wire

//--- sim/tb_ahb_slave.sv
// Directed testbench for the AHB slave of the AHB-to-APB bridge.
// Runs config register, window decode, valid/ready and ERROR response tests
// against the top level, stopping at the first mismatch.
`timescale 1ns/1ps
`default_nettype none

`include "ahb_slave_cfg.svh"

module tb_ahb_slave;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_XFERS = 50;  // rough count of bus transfers in all tests

	logic Hclk;
	logic Hresetn;
	logic [1:0] Htrans;
	logic [2:0] Hsize;
	logic Hreadyin;
	logic [`AHB_DATA_WIDTH-1:0] Hwdata;
	logic [`AHB_ADDR_WIDTH-1:0] Haddr;
	logic Hwrite;
	logic Hreadyout_in;
	logic [1:0] Hresp;
	logic Hreadyout;
	logic [`APB_SLAVES-1:0] Pselx_out;
	logic valid;
	logic [`AHB_DATA_WIDTH-1:0] config_reg_data;

	integer seed = 98;
	logic [`AHB_DATA_WIDTH-1:0] regs_model [9];  // expected register contents
	logic [`AHB_DATA_WIDTH-1:0] default_base [`APB_SLAVES] =
		'{`SLAVE_BASE_0, `SLAVE_BASE_1, `SLAVE_BASE_2, `SLAVE_BASE_3};

	ahb_slave_top uut (.*);

	initial
	begin
		Hclk = 1'b0;
		forever #(CLK_PERIOD / 2) Hclk = ~Hclk;
	end

	task automatic report_error(input string msg);
		$display("ERROR: %0t ns: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_resp(input ahb_slave_pkg::hresp_e exp_resp, input logic exp_ready);
		if (Hresp !== exp_resp || Hreadyout !== exp_ready)
			report_error($sformatf("Hresp %0h Hreadyout %b, expected %0h %b",
				Hresp, Hreadyout, exp_resp, exp_ready));
	endtask

	task automatic check_data(input logic [`AHB_DATA_WIDTH-1:0] exp_data);
		if (config_reg_data !== exp_data)
			report_error($sformatf("config_reg_data %h, expected %h", config_reg_data, exp_data));
	endtask

	task automatic check_sel(input logic [`APB_SLAVES-1:0] exp_sel, input logic exp_valid);
		if (Pselx_out !== exp_sel || valid !== exp_valid)
			report_error($sformatf("Pselx_out %b valid %b, expected %b %b",
				Pselx_out, valid, exp_sel, exp_valid));
	endtask

	// window hit from the expected base/size registers
	function automatic logic [`APB_SLAVES-1:0] expected_sel(input logic [`AHB_ADDR_WIDTH-1:0] a);
		logic [`APB_SLAVES-1:0] sel;
		logic [`AHB_DATA_WIDTH:0] limit;
		sel = '0;
		for (int k = 0; k < `APB_SLAVES; k++)
		begin
			limit = regs_model[2*k+1] + regs_model[2*k+2];
			sel[k] = (a >= regs_model[2*k+1]) && ({1'b0, a} < limit);
		end
		return sel;
	endfunction

	// drives one bus cycle and returns at the falling edge with settled outputs
	task automatic drive_phase(input ahb_slave_pkg::htrans_e t, input ahb_slave_pkg::hsize_e s,
		input logic [`AHB_ADDR_WIDTH-1:0] a, input logic w,
		input logic [`AHB_DATA_WIDTH-1:0] wdata = '0, input logic rdy_in = 1'b1,
		input logic rdy_out_in = 1'b1);
		@(posedge Hclk);
		Htrans <= t;
		Hsize <= s;
		Haddr <= a;
		Hwrite <= w;
		Hwdata <= wdata;
		Hreadyin <= rdy_in;
		Hreadyout_in <= rdy_out_in;
		@(negedge Hclk);
	endtask

	task automatic write_cfg(input int idx, input logic [`AHB_DATA_WIDTH-1:0] data);
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, idx, 1'b1);
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, '0, 1'b0, data);
		check_resp(ahb_slave_pkg::OKAY, 1'b1);
	endtask

	task automatic read_cfg(input int idx, input logic [`AHB_DATA_WIDTH-1:0] exp_data);
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, idx, 1'b0);
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, '0, 1'b0);
		check_data(exp_data);
	endtask

	// called right after the faulty address phase
	task automatic expect_error();
		logic [`AHB_ADDR_WIDTH-1:0] a;
		a = regs_model[5] + 32'h4;
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, '0, 1'b0);
		check_resp(ahb_slave_pkg::ERROR, 1'b0);
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, a, 1'b0);
		check_resp(ahb_slave_pkg::ERROR, 1'b1);
		check_sel(expected_sel(a), 1'b0);  // no forwarding during ERROR
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, '0, 1'b0);
		check_resp(ahb_slave_pkg::OKAY, 1'b1);
	endtask

	task automatic test_reset_defaults();
		@(negedge Hclk);
		check_resp(ahb_slave_pkg::OKAY, 1'b1);
		check_data('0);
		regs_model[0] = '0;
		for (int k = 0; k < `APB_SLAVES; k++)
		begin
			regs_model[2*k+1] = default_base[k];
			regs_model[2*k+2] = `SLAVE_SIZE_DEFAULT;
		end
		for (int i = 0; i < 9; i++)
			read_cfg(i, regs_model[i]);
	endtask

	task automatic test_reg_access();
		logic [`AHB_DATA_WIDTH-1:0] data;
		for (int i = 0; i < 9; i++)
		begin
			if (i == 0)
				data = 32'hDEAD_BEEF;  // reserved register stays zero
			else if (i % 2 == 1)
				data = 32'h4000_0000 + (i / 2) * 32'h0010_0000;
			else
				data = 32'h0000_0400 << (i / 2 - 1);
			write_cfg(i, data);
			if (i != 0)
				regs_model[i] = data;
			read_cfg(i, regs_model[i]);
		end
	endtask

	task automatic test_decode();
		logic [`AHB_ADDR_WIDTH-1:0] a;
		logic [`AHB_ADDR_WIDTH-1:0] old_base;
		for (int k = 0; k < `APB_SLAVES; k++)
		begin
			a = $unsigned($random(seed)) % regs_model[2*k+2];
			a[1:0] = 2'b00;
			a = a + regs_model[2*k+1];
			drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, a, 1'b0);
			check_sel(4'b0001 << k, 1'b1);
		end
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, 32'h2000_0000, 1'b0);
		check_sel('0, 1'b1);
		old_base = regs_model[3];
		write_cfg(3, 32'h7000_0000);
		regs_model[3] = 32'h7000_0000;
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, 32'h7000_0040, 1'b0);
		check_sel(4'b0010, 1'b1);
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, old_base + 32'h40, 1'b0);
		check_sel('0, 1'b1);
	endtask

	task automatic test_valid_ready();
		logic [`AHB_ADDR_WIDTH-1:0] a;
		a = regs_model[1] + 32'h10;
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, a, 1'b0);
		check_sel(expected_sel(a), 1'b0);
		drive_phase(ahb_slave_pkg::BUSY, ahb_slave_pkg::WORD, a, 1'b0);
		check_sel(expected_sel(a), 1'b0);
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, a, 1'b0, '0, 1'b0);
		check_sel(expected_sel(a), 1'b0);  // Hreadyin low
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, a, 1'b0);
		check_sel(expected_sel(a), 1'b1);
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, '0, 1'b0, '0, 1'b1, 1'b0);
		check_resp(ahb_slave_pkg::OKAY, 1'b0);  // slave stretches the read
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, '0, 1'b0);
		check_resp(ahb_slave_pkg::OKAY, 1'b1);
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, 32'd3, 1'b1);
		check_sel(expected_sel(32'd3), 1'b0);
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, '0, 1'b0, regs_model[3], 1'b1, 1'b0);
		check_resp(ahb_slave_pkg::OKAY, 1'b1);  // config write ignores Hreadyout_in
		read_cfg(3, regs_model[3]);
	endtask

	task automatic test_errors();
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, 32'h2000_0002, 1'b0);
		expect_error();
		drive_phase(ahb_slave_pkg::IDLE, ahb_slave_pkg::WORD, 32'h2000_0000, 1'b0);
		drive_phase(ahb_slave_pkg::SEQ, ahb_slave_pkg::WORD, 32'h2000_0004, 1'b0);
		expect_error();
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::WORD, 32'h2000_0010, 1'b0);
		drive_phase(ahb_slave_pkg::SEQ, ahb_slave_pkg::WORD, 32'h2000_0014, 1'b0);
		check_resp(ahb_slave_pkg::OKAY, 1'b1);
		drive_phase(ahb_slave_pkg::SEQ, ahb_slave_pkg::HALFWORD, 32'h2000_0018, 1'b0);
		check_resp(ahb_slave_pkg::OKAY, 1'b1);  // matching SEQ passes
		expect_error();
		drive_phase(ahb_slave_pkg::NONSEQ, ahb_slave_pkg::DWORD, 32'h2000_0020, 1'b0);
		expect_error();
	endtask

	initial
	begin
		Hresetn = 1'b0;
		Htrans = ahb_slave_pkg::IDLE;
		Hsize = ahb_slave_pkg::WORD;
		Hreadyin = 1'b1;
		Hwdata = '0;
		Haddr = '0;
		Hwrite = 1'b0;
		Hreadyout_in = 1'b1;
		repeat (4) @(posedge Hclk);
		Hresetn <= 1'b1;
		test_reset_defaults();
		test_reg_access();
		test_decode();
		test_valid_ready();
		test_errors();
		repeat (2) @(negedge Hclk);  // last ERROR sequence runs to its end
		if (uut.u_err_resp.u_chk.failures == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
		begin
			$display("ERROR: %0t ns: %0d response assertions failed", $time,
				uut.u_err_resp.u_chk.failures);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	// stop at the first failed response assertion
	initial
	begin
		wait (uut.u_err_resp.u_chk.failures != 0);
		report_error("a response handshake assertion failed");
	end

	initial
	begin
		#(NUM_XFERS * 10 * CLK_PERIOD);
		$display("ERROR: %0t ns: watchdog expired before the tests finished", $time);
		$display("Testbench failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hdl/ahb_slave_pkg.sv
hdl/ahb_xfer_if.sv
hdl/ahb_addr_phase.sv
hdl/ahb_cfg_regs.sv
hdl/ahb_slave_decode.sv
hdl/ahb_err_resp.sv
hdl/ahb_slave_top.sv
sim/ahb_slave_chk.sv
sim/tb_ahb_slave.sv
